// ==== source/switch_macros.svh ====
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// ====================
// switch geometry
// ====================
`define NUM_OUTPORTS 4
`define LUT_DEPTH    32
`define BUF_DEPTH    4

// head flit field positions
`define REQ_MSB  31
`define REQ_LSB  27
`define DEST_MSB 26
`define DEST_LSB 22

`endif

// ==== source/chiplet_types_pkg.sv ====
`include "switch_macros.svh"

package chiplet_types_pkg;

    // ====================
    // node ids
    // ====================
    localparam int NODE_ID_W = 5;

    // zero acts as a wildcard in route table fields
    typedef logic [NODE_ID_W-1:0] node_id_t;

    // ====================
    // head flit
    // ====================
    localparam int FLIT_W = 32;

    typedef logic [FLIT_W-1:0] flit_t;

    function automatic node_id_t flit_req(flit_t flit);
        return flit[`REQ_MSB:`REQ_LSB];
    endfunction

    function automatic node_id_t flit_dest(flit_t flit);
        return flit[`DEST_MSB:`DEST_LSB];
    endfunction

endpackage

// ==== source/switch_pkg.sv ====
`include "switch_macros.svh"

package switch_pkg;
    import chiplet_types_pkg::*;

    typedef logic [$clog2(`NUM_OUTPORTS)-1:0] port_sel_t;
    typedef logic [$clog2(`LUT_DEPTH)-1:0]    lut_index_t;
    typedef logic [$clog2(`BUF_DEPTH+1)-1:0]  credit_t;

    // ====================
    // route entry
    // ====================
    // requester in the top bits, then destination, port select at the bottom
    localparam int ENTRY_PORT_W   = $bits(port_sel_t);
    localparam int ENTRY_DEST_LSB = ENTRY_PORT_W;
    localparam int ENTRY_REQ_LSB  = ENTRY_DEST_LSB + $bits(node_id_t);
    localparam int ENTRY_W        = ENTRY_REQ_LSB + $bits(node_id_t);

    typedef logic [ENTRY_W-1:0] route_entry_t;

    function automatic node_id_t entry_req(route_entry_t entry);
        return entry[ENTRY_REQ_LSB +: $bits(node_id_t)];
    endfunction

    function automatic node_id_t entry_dest(route_entry_t entry);
        return entry[ENTRY_DEST_LSB +: $bits(node_id_t)];
    endfunction

    function automatic port_sel_t entry_port(route_entry_t entry);
        return entry[0 +: ENTRY_PORT_W];
    endfunction

endpackage

// ==== source/route_table.sv ====
`timescale 1ns/1ps

`include "switch_macros.svh"

module route_table
    import switch_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr,
    input  lut_index_t                    wr_index,
    input  logic                          wr_valid,
    input  route_entry_t                  wr_entry,
    output route_entry_t [`LUT_DEPTH-1:0] entries,
    output logic [`LUT_DEPTH-1:0]         entry_valid
);

    // ====================
    // route storage
    // ====================
    // entry fields are written on every strobe, even an invalidating one
    always_ff @(posedge clk) begin
        if (wr) begin
            entries[wr_index] <= wr_entry;
        end
    end

    // ====================
    // valid bits
    // ====================
    // a write with wr_valid low takes the entry out of the search
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (wr) begin
            entry_valid[wr_index] <= wr_valid;
        end
    end

endmodule

// ==== source/buffer_credit.sv ====
`timescale 1ns/1ps

`include "switch_macros.svh"

module buffer_credit
    import switch_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`NUM_OUTPORTS-1:0] credit_return,
    input  logic                     consume,
    input  port_sel_t                consume_sel,
    output logic [`NUM_OUTPORTS-1:0] buffer_available
);

    localparam credit_t FULL = credit_t'(`BUF_DEPTH);

    credit_t                  count [`NUM_OUTPORTS];
    logic [`NUM_OUTPORTS-1:0] take;

    // a consume only counts against a port that still holds credit
    always_comb begin
        for (int p = 0; p < `NUM_OUTPORTS; p++) begin
            take[p] = consume && (consume_sel == port_sel_t'(p)) && (count[p] != '0);
        end
    end

    // ====================
    // counters
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < `NUM_OUTPORTS; p++) begin
                count[p] <= FULL;
            end
        end else begin
            for (int p = 0; p < `NUM_OUTPORTS; p++) begin
                // return and take in one cycle cancel out
                if (credit_return[p] && !take[p]) begin
                    if (count[p] != FULL) begin
                        count[p] <= count[p] + 1'b1;
                    end
                end else if (take[p] && !credit_return[p]) begin
                    count[p] <= count[p] - 1'b1;
                end
            end
        end
    end

    // downstream has room while any credit is left
    always_comb begin
        for (int p = 0; p < `NUM_OUTPORTS; p++) begin
            buffer_available[p] = (count[p] != '0);
        end
    end

endmodule

// ==== source/route_compute.sv ====
`timescale 1ns/1ps

`include "switch_macros.svh"

module route_compute
    import chiplet_types_pkg::*, switch_pkg::*;
#(
    parameter node_id_t NODE = node_id_t'(1)
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          head_valid,
    input  flit_t                         head_flit,
    input  route_entry_t [`LUT_DEPTH-1:0] lut_entries,
    input  logic [`LUT_DEPTH-1:0]         lut_valid,
    input  logic [`NUM_OUTPORTS-1:0]      buffer_available,
    output logic                          route_valid,
    output port_sel_t                     out_sel
);

    node_id_t              req;
    node_id_t              dest;
    logic [`LUT_DEPTH-1:0] hit;
    logic                  strict_found;
    logic                  loose_found;
    port_sel_t             strict_sel;
    port_sel_t             loose_sel;
    port_sel_t             next_sel;

    assign req  = flit_req(head_flit);
    assign dest = flit_dest(head_flit);

    // ====================
    // entry match
    // ====================
    // zero in a table field matches anything, a zero destination in the flit too
    always_comb begin
        for (int i = 0; i < `LUT_DEPTH; i++) begin
            hit[i] = lut_valid[i]
                && (entry_req(lut_entries[i]) == '0 || entry_req(lut_entries[i]) == req)
                && (entry_dest(lut_entries[i]) == '0 || dest == '0
                    || entry_dest(lut_entries[i]) == dest);
        end
    end

    // ====================
    // priority scans
    // ====================
    // lowest index wins; strict also needs space on the entry's port
    always_comb begin
        strict_found = 1'b0;
        strict_sel   = '0;
        loose_found  = 1'b0;
        loose_sel    = '0;
        for (int i = 0; i < `LUT_DEPTH; i++) begin
            if (hit[i] && !loose_found) begin
                loose_found = 1'b1;
                loose_sel   = entry_port(lut_entries[i]);
            end
            if (hit[i] && !strict_found && buffer_available[entry_port(lut_entries[i])]) begin
                strict_found = 1'b1;
                strict_sel   = entry_port(lut_entries[i]);
            end
        end
    end

    // local delivery overrides the table
    always_comb begin
        if (dest == NODE) begin
            next_sel = '0;
        end else if (strict_found) begin
            next_sel = strict_sel;
        end else if (loose_found) begin
            next_sel = loose_sel;
        end else begin
            next_sel = '0;
        end
    end

    // result register, one lookup per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            route_valid <= 1'b0;
            out_sel     <= '0;
        end else begin
            route_valid <= head_valid;
            if (head_valid) begin
                out_sel <= next_sel;
            end
        end
    end

endmodule

// ==== source/switch_route_top.sv ====
`timescale 1ns/1ps

`include "switch_macros.svh"

module switch_route_top
    import chiplet_types_pkg::*, switch_pkg::*;
#(
    parameter node_id_t NODE = node_id_t'(1)
) (
    input  logic                     clk,
    input  logic                     reset,

    // head flit
    input  logic                     head_valid,
    input  flit_t                    head_flit,

    // table programming
    input  logic                     lut_wr,
    input  lut_index_t               lut_wr_index,
    input  logic                     lut_wr_valid,
    input  route_entry_t             lut_wr_entry,

    // credits from downstream buffers
    input  logic [`NUM_OUTPORTS-1:0] credit_return,

    // routing result
    output logic                     route_valid,
    output port_sel_t                out_sel,

    output logic [`NUM_OUTPORTS-1:0] buffer_available
);

    route_entry_t [`LUT_DEPTH-1:0] lut_entries;
    logic [`LUT_DEPTH-1:0]         lut_valid;

    route_table u_table (
        .clk         (clk),
        .reset       (reset),
        .wr          (lut_wr),
        .wr_index    (lut_wr_index),
        .wr_valid    (lut_wr_valid),
        .wr_entry    (lut_wr_entry),
        .entries     (lut_entries),
        .entry_valid (lut_valid)
    );

    // each issued route takes one credit from its port
    buffer_credit u_credit (
        .clk              (clk),
        .reset            (reset),
        .credit_return    (credit_return),
        .consume          (route_valid),
        .consume_sel      (out_sel),
        .buffer_available (buffer_available)
    );

    route_compute #(
        .NODE (NODE)
    ) u_compute (
        .clk              (clk),
        .reset            (reset),
        .head_valid       (head_valid),
        .head_flit        (head_flit),
        .lut_entries      (lut_entries),
        .lut_valid        (lut_valid),
        .buffer_available (buffer_available),
        .route_valid      (route_valid),
        .out_sel          (out_sel)
    );

endmodule

// ==== bench/switch_route_assertions.sv ====
`timescale 1ns/1ps

`include "switch_macros.svh"

module switch_route_assertions
    import switch_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      head_valid,
    input logic      route_valid,
    input port_sel_t out_sel
);

    int failures = 0;

    // one result per head flit, exactly one cycle later
    a_follow: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (route_valid == $past(head_valid)))
    else begin
        failures++;
        $error("route_valid does not follow head_valid by one cycle");
    end

    a_port_range: assert property (@(posedge clk) disable iff (reset)
        route_valid |-> (!$isunknown(out_sel) && out_sel < `NUM_OUTPORTS))
    else begin
        failures++;
        $error("out_sel outside the output port range");
    end

    a_reset_quiet: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !route_valid)
    else begin
        failures++;
        $error("route_valid high while reset is held");
    end

endmodule

bind switch_route_top switch_route_assertions u_assert (
    .clk         (clk),
    .reset       (reset),
    .head_valid  (head_valid),
    .route_valid (route_valid),
    .out_sel     (out_sel)
);

// ==== bench/switch_route_tb.sv ====
`timescale 1ns/1ps

`include "switch_macros.svh"

module switch_route_tb
    import chiplet_types_pkg::*, switch_pkg::*;
;

    localparam node_id_t NODE_ID = node_id_t'(3);

    logic                     clk;
    logic                     reset;
    logic                     head_valid;
    flit_t                    head_flit;
    logic                     lut_wr;
    lut_index_t               lut_wr_index;
    logic                     lut_wr_valid;
    route_entry_t             lut_wr_entry;
    logic [`NUM_OUTPORTS-1:0] credit_return;
    logic                     route_valid;
    port_sel_t                out_sel;
    logic [`NUM_OUTPORTS-1:0] buffer_available;

    // table and credit mirror of the reference model
    logic      mirror_valid  [`LUT_DEPTH];
    node_id_t  mirror_req    [`LUT_DEPTH];
    node_id_t  mirror_dest   [`LUT_DEPTH];
    port_sel_t mirror_port   [`LUT_DEPTH];
    int        mirror_credit [`NUM_OUTPORTS];
    logic      exp_valid;
    port_sel_t exp_sel;

    logic [31:0] rng_state;
    int          checks;
    int          errors;

    always #20 clk = ~clk;

    switch_route_top #(
        .NODE (NODE_ID)
    ) u_dut (
        .clk              (clk),
        .reset            (reset),
        .head_valid       (head_valid),
        .head_flit        (head_flit),
        .lut_wr           (lut_wr),
        .lut_wr_index     (lut_wr_index),
        .lut_wr_valid     (lut_wr_valid),
        .lut_wr_entry     (lut_wr_entry),
        .credit_return    (credit_return),
        .route_valid      (route_valid),
        .out_sel          (out_sel),
        .buffer_available (buffer_available)
    );

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [`NUM_OUTPORTS-1:0] mirror_avail();
        logic [`NUM_OUTPORTS-1:0] a;
        for (int p = 0; p < `NUM_OUTPORTS; p++) begin
            a[p] = (mirror_credit[p] != 0);
        end
        return a;
    endfunction

    // ====================
    // reference routing
    // ====================
    function automatic port_sel_t expected_port(flit_t f, logic [`NUM_OUTPORTS-1:0] avail);
        node_id_t  r;
        node_id_t  d;
        logic      hit;
        logic      loose_hit;
        port_sel_t loose;
        r = f[`REQ_MSB:`REQ_LSB];
        d = f[`DEST_MSB:`DEST_LSB];
        loose_hit = 1'b0;
        loose = '0;
        if (d == NODE_ID) begin
            return '0;
        end
        for (int i = 0; i < `LUT_DEPTH; i++) begin
            hit = mirror_valid[i] && (mirror_req[i] == 0 || mirror_req[i] == r)
                && (mirror_dest[i] == 0 || d == 0 || mirror_dest[i] == d);
            if (hit && avail[mirror_port[i]]) begin
                return mirror_port[i];
            end
            if (hit && !loose_hit) begin
                loose_hit = 1'b1;
                loose = mirror_port[i];
            end
        end
        return loose;
    endfunction

    // lookup sees the table and credits from before this edge
    always @(posedge clk) begin : reference_model
        port_sel_t next_sel;
        logic      take;
        next_sel = '0;
        if (reset) begin
            for (int i = 0; i < `LUT_DEPTH; i++) begin
                mirror_valid[i] = 1'b0;
            end
            for (int p = 0; p < `NUM_OUTPORTS; p++) begin
                mirror_credit[p] = `BUF_DEPTH;
            end
            exp_valid = 1'b0;
            exp_sel = '0;
        end else begin
            if (head_valid) begin
                next_sel = expected_port(head_flit, mirror_avail());
            end
            for (int p = 0; p < `NUM_OUTPORTS; p++) begin
                take = exp_valid && exp_sel == p && mirror_credit[p] != 0;
                if (credit_return[p] && !take) begin
                    if (mirror_credit[p] < `BUF_DEPTH) begin
                        mirror_credit[p]++;
                    end
                end else if (take && !credit_return[p]) begin
                    mirror_credit[p]--;
                end
            end
            if (lut_wr) begin
                mirror_valid[lut_wr_index] = lut_wr_valid;
                mirror_req[lut_wr_index]   = lut_wr_entry[11:7];
                mirror_dest[lut_wr_index]  = lut_wr_entry[6:2];
                mirror_port[lut_wr_index]  = lut_wr_entry[1:0];
            end
            exp_valid = head_valid;
            if (head_valid) begin
                exp_sel = next_sel;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            check_value("route_valid", route_valid, exp_valid);
            if (exp_valid) begin
                check_value("out_sel", out_sel, exp_sel);
            end
            check_value("buffer_available", buffer_available, mirror_avail());
        end
    end

    // ====================
    // stimulus
    // ====================
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            head_valid    <= 1'b0;
            lut_wr        <= 1'b0;
            credit_return <= '0;
        end
    endtask

    task automatic drive_flit(input node_id_t req, input node_id_t dest);
        logic [31:0] r;
        r = xorshift();
        @(posedge clk);
        head_valid <= 1'b1;
        head_flit  <= {req, dest, r[21:0]};
    endtask

    task automatic write_entry(input lut_index_t idx, input logic valid, input node_id_t req,
                               input node_id_t dest, input port_sel_t port);
        @(posedge clk);
        head_valid   <= 1'b0;
        lut_wr       <= 1'b1;
        lut_wr_index <= idx;
        lut_wr_valid <= valid;
        lut_wr_entry <= {req, dest, port};
        idle(1);
    endtask

    task automatic return_credits(input logic [`NUM_OUTPORTS-1:0] ports, input int n);
        repeat (n) begin
            @(posedge clk);
            head_valid    <= 1'b0;
            credit_return <= ports;
        end
        idle(1);
    endtask

    task automatic wait_route();
        int n;
        n = 0;
        @(negedge clk);
        while (route_valid !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (route_valid !== 1'b1) begin
            errors++;
            $display("timeout: no route_valid came back for a head flit");
        end
    endtask

    task automatic wait_quiet();
        int n;
        n = 0;
        @(negedge clk);
        while (route_valid !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (route_valid !== 1'b0) begin
            errors++;
            $display("timeout: route_valid never returned low");
        end
    endtask

    // one spaced lookup with a known answer
    task automatic route_check(input node_id_t req, input node_id_t dest, input port_sel_t want);
        drive_flit(req, dest);
        idle(1);
        wait_route();
        check_value("out_sel", out_sel, want);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int          e0;
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        head_valid = 1'b0;
        head_flit = '0;
        lut_wr = 1'b0;
        lut_wr_index = '0;
        lut_wr_valid = 1'b0;
        lut_wr_entry = '0;
        credit_return = '0;
        rng_state = 32'd5;
        checks = 0;
        errors = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        e0 = errors;
        idle(3);
        @(negedge clk);
        check_value("route_valid", route_valid, 1'b0);
        check_value("buffer_available", buffer_available, 4'hf);
        route_check(2, 9, 0);
        route_check(6, 12, 0);
        end_test("reset state", e0);

        e0 = errors;
        write_entry(0, 1'b1, 5, 3, 2);
        write_entry(1, 1'b1, 0, 3, 1);
        route_check(5, 3, 0);
        route_check(9, 3, 0);
        write_entry(1, 1'b0, 0, 3, 1);
        end_test("local delivery", e0);

        e0 = errors;
        write_entry(4, 1'b1, 7, 9, 3);
        write_entry(5, 1'b1, 0, 9, 2);
        write_entry(6, 1'b1, 7, 0, 1);
        route_check(7, 9, 3);
        route_check(2, 9, 2);
        route_check(7, 12, 1);
        route_check(2, 0, 2);
        route_check(7, 0, 3);
        route_check(2, 12, 0);
        end_test("priority and wildcards", e0);

        // drain ports 3, 2 and 1 in turn
        e0 = errors;
        repeat (11) drive_flit(7, 9);
        idle(1);
        wait_quiet();
        check_value("buffer_available[3:1]", buffer_available[3:1], 3'b000);
        route_check(7, 9, 3);
        return_credits(4'b0010, 1);
        route_check(7, 9, 1);
        end_test("strict versus loose", e0);

        e0 = errors;
        return_credits(4'b1111, 6);
        @(negedge clk);
        check_value("buffer_available", buffer_available, 4'hf);
        repeat (4) route_check(7, 9, 3);
        route_check(7, 9, 2);
        // port 3 has space again, so only the invalidation keeps entry 4 out
        return_credits(4'b1000, 1);
        write_entry(4, 1'b0, 7, 9, 3);
        route_check(7, 9, 2);
        end_test("credit return and invalidation", e0);

        e0 = errors;
        for (int k = 0; k < 200; k++) begin
            r = xorshift();
            @(posedge clk);
            head_valid    <= 1'b1;
            head_flit     <= {node_id_t'(r[2:0]), node_id_t'(r[5:3]), r[27:6]};
            lut_wr        <= (r[9:8] == 2'b00);
            lut_wr_index  <= r[14:10];
            lut_wr_valid  <= r[15] | r[16];
            lut_wr_entry  <= {node_id_t'(r[19:17]), node_id_t'(r[22:20]), r[24:23]};
            credit_return <= r[31:28] & {`NUM_OUTPORTS{r[25]}};
            if (r[26]) begin
                idle(1);
            end
        end
        idle(1);
        wait_quiet();
        end_test("random", e0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_assert.failures);
        if (errors == 0 && u_dut.u_assert.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== switch_route.f ====
+incdir+source
source/chiplet_types_pkg.sv
source/switch_pkg.sv
source/route_table.sv
source/buffer_credit.sv
source/route_compute.sv
source/switch_route_top.sv
bench/switch_route_assertions.sv
bench/switch_route_tb.sv
